// ==== verilog.f ====
verilog/rvIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/cpuIfs.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/regFile.sv
verilog/dataMem.sv
verilog/instMem.sv
verilog/singleCpu.sv
sim/singleCpuChecker.sv
sim/singleCpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the single-cycle core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --assert --top-module singleCpuTb -f verilog.f -o simv &&
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== sim/singleCpuTb.sv ====
`default_nettype none

module singleCpuTb;

    localparam int numTests   = 5;
    localparam int progLen    = 48;
    localparam int runCycles  = 120;
    localparam int cycleLimit = numTests * (2 + 64 + runCycles) + 100;

    logic        CLK = 1'b0;
    logic        rst;
    logic        run;
    logic        imemWe;
    logic [5:0]  imemAddr;
    logic [31:0] imemData;
    logic [31:0] OUT;
    logic [31:0] pc;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    // Reference model state
    // Data memory persists across tests like the DUT's
    logic [31:0] progMem [64];
    logic [31:0] mRegs [32];
    logic [31:0] mData [64];
    bit          mWritten [64];
    logic [31:0] mPc;

    int passCount  = 0;
    int failCount  = 0;
    int cycleCount = 0;

    singleCpu #(.imemDepth(64), .dmemDepth(64)) dut_i (
        .CLK(CLK), .rst(rst), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemData(imemData), .OUT(OUT), .pc(pc), .wbValid(wbValid), .wbReg(wbReg),
        .wbData(wbData)
    );

    initial begin
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Simulation timed out after %0d cycles", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s at model pc %h is %h, expected %h",
                     $time, what, mPc, got, exp);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // RV32I encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000 | {1'b0, op == 7'b0000011, 1'b0}, rd, op};  // lw has funct3 010
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [4:0] randReg();
        return 5'($urandom_range(0, 7));  // x0..x7 only
    endfunction

    function automatic logic [31:0] randRtype(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        int k;
        k = int'($urandom_range(0, 4));
        case (k)
            0:       return encR(7'b0000000, 3'b000, rd, rs1, rs2);  // add
            1:       return encR(7'b0100000, 3'b000, rd, rs1, rs2);  // sub
            2:       return encR(7'b0000000, 3'b111, rd, rs1, rs2);  // and
            3:       return encR(7'b0000000, 3'b110, rd, rs1, rs2);  // or
            default: return encR(7'b0000000, 3'b010, rd, rs1, rs2);  // slt
        endcase
    endfunction

    // 0 R-type, 1 addi, 2 sw, 3 lw, 4 beq
    function automatic int pickKind(input int focus);
        int weights [5];
        int r;
        case (focus)
            0:       weights = '{60, 15, 10, 10, 5};
            1:       weights = '{15, 60, 10, 10, 5};
            2:       weights = '{15, 15, 35, 30, 5};
            3:       weights = '{20, 20, 10, 10, 40};
            default: weights = '{20, 20, 20, 20, 20};
        endcase
        r = int'($urandom_range(0, 99));
        for (int k = 0; k < 5; k++) begin
            if (r < weights[3'(k)]) return k;
            r -= weights[3'(k)];
        end
        return 0;
    endfunction

    function automatic string testName(input int t);
        case (t)
            0:       return "R-type ALU";
            1:       return "addi immediates";
            2:       return "store and load";
            3:       return "branches";
            default: return "mixed";
        endcase
    endfunction

    task automatic genProgram(input int focus);
        int          kind;
        int          off;
        int          maxTarget;
        logic [4:0]  rs1;
        logic [5:0]  word;
        bit          avail [64];
        logic [5:0]  cand [$];
        maxTarget = 0;  // Instructions at or past this index always execute
        for (int w = 0; w < 64; w++) avail[6'(w)] = mWritten[6'(w)];
        for (int j = 0; j < progLen; j++) begin
            kind = (j == 0) ? 0 : (j <= 7) ? 1 : pickKind(focus);
            cand.delete();
            for (int w = 0; w < 64; w++) if (avail[6'(w)]) cand.push_back(6'(w));
            if (kind == 3 && cand.size() == 0) kind = 2;  // Nothing known to load yet
            case (kind)
                0: progMem[6'(j)] = randRtype(randReg(), randReg(), randReg());
                1: begin
                    rs1 = (j <= 7) ? 5'd0 : randReg();  // First ones seed x1..x7
                    progMem[6'(j)] = encI(7'b0010011, (j <= 7) ? 5'(j) : randReg(), rs1,
                                          12'($urandom_range(0, 4095)));
                end
                2: begin
                    word = 6'($urandom_range(0, 63));
                    progMem[6'(j)] = encS(5'd0, randReg(), {4'b0, word, 2'b00});
                    if (j >= maxTarget) avail[word] = 1'b1;
                end
                3: begin
                    word = cand[$urandom_range(0, cand.size() - 1)];
                    progMem[6'(j)] = encI(7'b0000011, randReg(), 5'd0, {4'b0, word, 2'b00});
                end
                default: begin
                    off = int'($urandom_range(1, 4));
                    rs1 = randReg();
                    progMem[6'(j)] = encB(rs1, ($urandom_range(0, 1) == 0) ? rs1 : randReg(),
                                          13'(off * 4));
                    if (j + off > maxTarget) maxTarget = j + off;
                end
            endcase
        end
        for (int j = progLen; j < 64; j++) progMem[6'(j)] = encB(5'd0, 5'd0, 13'd0);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            @(negedge CLK);
            imemWe   = 1'b1;
            imemAddr = 6'(i);
            imemData = progMem[6'(i)];
        end
        @(negedge CLK);
        imemWe = 1'b0;
    endtask

    // Compare the DUT with the model for the instruction at pc, then commit it
    task automatic checkInstruction();
        logic [31:0] inst, a, b, immI, immS, immB, addr, eData, nextPc;
        logic [4:0]  rd;
        logic [5:0]  word;
        logic        eValid;
        logic        doStore;
        inst    = progMem[mPc[7:2]];
        rd      = inst[11:7];
        a       = mRegs[inst[19:15]];
        b       = mRegs[inst[24:20]];
        immI    = {{20{inst[31]}}, inst[31:20]};
        immS    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        eValid  = 1'b0;
        eData   = '0;
        doStore = 1'b0;
        nextPc  = mPc + 32'd4;
        addr    = a + ((inst[6:0] == 7'b0100011) ? immS : immI);
        word    = addr[7:2];
        case (inst[6:0])
            7'b0110011: begin
                eValid = 1'b1;
                case (inst[14:12])
                    3'b000:  eData = inst[30] ? a - b : a + b;
                    3'b010:  eData = {31'b0, $signed(a) < $signed(b)};
                    3'b110:  eData = a | b;
                    default: eData = a & b;
                endcase
            end
            7'b0010011: begin
                eValid = 1'b1;
                eData  = a + immI;
            end
            7'b0000011: begin
                eValid = 1'b1;
                eData  = mData[word];
            end
            7'b0100011: doStore = 1'b1;
            7'b1100011: if (a == b) nextPc = mPc + immB;
            default: ;
        endcase
        eValid = eValid && (rd != 5'd0);  // x0 is never written
        checkValue("pc", pc, mPc);
        checkValue("OUT", OUT, inst);
        checkValue("wbValid", {31'b0, wbValid}, {31'b0, eValid});
        if (eValid) begin
            checkValue("wbReg", {27'b0, wbReg}, {27'b0, rd});
            checkValue("wbData", wbData, eData);
            mRegs[rd] = eData;
        end
        if (doStore) begin
            mData[word]     = b;
            mWritten[word]  = 1'b1;
        end
        mPc = nextPc;
    endtask

    task automatic runTest(input int t);
        int failsBefore;
        failsBefore = failCount;
        @(negedge CLK);
        rst = 1'b1;
        run = 1'b1;  // Reset has to win over run
        repeat (2) begin
            @(negedge CLK);
            checkValue("pc in reset", pc, 32'd0);
            checkValue("wbValid in reset", {31'b0, wbValid}, 32'd0);
        end
        rst = 1'b0;
        run = 1'b0;
        for (int i = 0; i < 32; i++) mRegs[5'(i)] = '0;
        mPc = '0;
        genProgram(t);
        loadProgram();
        for (int c = 0; c < runCycles; c++) begin
            @(negedge CLK);
            run = 1'b1;
            #1;  // Let the combinational outputs settle
            checkInstruction();
        end
        @(negedge CLK);
        run = 1'b0;
        $display("Test %0d (%s) finished with %0d mismatches", t, testName(t),
                 failCount - failsBefore);
    endtask

    initial begin
        rst      = 1'b1;
        run      = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(90904));
        for (int t = 0; t < numTests; t++) runTest(t);
        $display("Checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/singleCpuChecker.sv ====
`default_nettype none

module singleCpuChecker (
    input logic        CLK,
    input logic        rst,
    input logic        run,
    input logic [31:0] pc,
    input logic        wbValid,
    input logic [4:0]  wbReg
);

    // No writeback is traced while the core sits in reset
    noWbInReset: assert property (@(posedge CLK) rst |-> !wbValid)
        else $error("wbValid high during reset");

    pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc %h is not word-aligned", pc);

    // A held core keeps its place
    pcHoldsWhenStopped: assert property (@(posedge CLK) disable iff (rst)
        !run |=> $stable(pc))
        else $error("pc moved while run was low");

    noWbToX0: assert property (@(posedge CLK) wbValid |-> wbReg != 5'd0)
        else $error("writeback traced for x0");

endmodule

bind singleCpu singleCpuChecker checker_i (
    .CLK(CLK), .rst(rst), .run(run), .pc(pc), .wbValid(wbValid), .wbReg(wbReg)
);

`default_nettype wire

// ==== verilog/singleCpu.sv ====
`default_nettype none

module singleCpu #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          imemWe,
    input  logic [5:0]                    imemAddr,
    input  logic [31:0]                   imemData,
    output logic [31:0]                   OUT,
    output logic [rvIsaPkg::xlen-1:0]     pc,
    output logic                          wbValid,
    output logic [rvIsaPkg::regAddrW-1:0] wbReg,
    output logic [rvIsaPkg::xlen-1:0]     wbData
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    logic [xlen-1:0] inst;
    logic [xlen-1:0] immI, immS, immB, imm;
    logic [xlen-1:0] aluB, aluY;
    logic [xlen-1:0] pcPlus4, pcBranch, nextPc;
    logic            zero;
    logic            commit;  // This cycle's instruction takes effect
    ctrlT            ctrl;
    aluOpT           aluOp;

    regFileIf rfBus ();
    dataMemIf dmBus ();

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    instMem #(.imemDepth(imemDepth)) instMem_i (
        .CLK(CLK), .loadWe(imemWe), .loadAddr(imemAddr), .loadData(imemData),
        .fetchAddr(pc), .inst(inst)
    );

    controlUnit controlUnit_i (
        .opcode(inst[6:0]), .funct3(inst[14:12]), .funct7b5(inst[30]),
        .ctrl(ctrl), .aluOp(aluOp)
    );

    // Sign-extended immediates
    assign immI = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign immS = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm  = ctrl.immStore ? immS : immI;

    assign commit = run && !rst;

    // Register file side
    assign rfBus.rs1 = inst[19:15];
    assign rfBus.rs2 = inst[24:20];
    assign rfBus.rd  = inst[11:7];
    assign rfBus.wd  = ctrl.memToReg ? dmBus.rdata : aluY;
    assign rfBus.we  = ctrl.regWrite && commit && (inst[11:7] != '0);

    regFile regFile_i (.CLK(CLK), .rst(rst), .port(rfBus));

    assign aluB = ctrl.aluSrc ? imm : rfBus.rd2;

    alu alu_i (.a(rfBus.rd1), .b(aluB), .op(aluOp), .y(aluY), .zero(zero));

    // Data memory side
    assign dmBus.addr = aluY;
    assign dmBus.wd   = rfBus.rd2;
    assign dmBus.we   = ctrl.memWrite && commit;

    dataMem #(.dmemDepth(dmemDepth)) dataMem_i (.CLK(CLK), .port(dmBus));

    // Next PC, branch only on beq with equal operands
    assign pcPlus4  = pc + 32'd4;
    assign pcBranch = pc + immB;
    assign nextPc   = (ctrl.branch && zero) ? pcBranch : pcPlus4;

    // Trace of the instruction at pc
    assign OUT     = inst;
    assign wbValid = rfBus.we;
    assign wbReg   = rfBus.rd;
    assign wbData  = rfBus.wd;

endmodule

`default_nettype wire

// ==== verilog/instMem.sv ====
`default_nettype none

module instMem #(
    parameter int imemDepth = 64
) (
    input  logic                      CLK,
    input  logic                      loadWe,
    input  logic [5:0]                loadAddr,
    input  logic [31:0]               loadData,
    input  logic [rvIsaPkg::xlen-1:0] fetchAddr,
    output logic [31:0]               inst
);
    localparam int idxW = $clog2(imemDepth);

    logic [31:0] mem [imemDepth];

    // Program load, usable whether or not the core runs
    always_ff @(posedge CLK) begin
        if (loadWe) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign inst = mem[fetchAddr[idxW+1:2]];  // PC is a byte address

endmodule

`default_nettype wire

// ==== verilog/dataMem.sv ====
`default_nettype none

module dataMem #(
    parameter int dmemDepth = 64
) (
    input logic CLK,
    dataMemIf.mem port
);
    import rvIsaPkg::*;

    localparam int idxW = $clog2(dmemDepth);

    logic [xlen-1:0] mem [dmemDepth];
    logic [idxW-1:0] wordIdx;

    // Word addressing, low two bits ignored
    assign wordIdx = port.addr[idxW+1:2];

    always_ff @(posedge CLK) begin
        if (port.we) begin
            mem[wordIdx] <= port.wd;
        end
    end

    assign port.rdata = mem[wordIdx];  // lw result in the same cycle

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`default_nettype none

module regFile (
    input logic CLK,
    input logic rst,
    regFileIf.rf port
);
    import rvIsaPkg::*;

    localparam int numRegs = 2 ** regAddrW;

    logic [xlen-1:0] regs [numRegs];

    // Single write port
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (port.we && port.rd != '0) begin
            regs[port.rd] <= port.wd;
        end
    end

    // Combinational reads, x0 forced to zero
    assign port.rd1 = (port.rs1 == '0) ? '0 : regs[port.rs1];
    assign port.rd2 = (port.rs2 == '0) ? '0 : regs[port.rs2];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
    input  logic              [rvIsaPkg::xlen-1:0] a,
    input  logic              [rvIsaPkg::xlen-1:0] b,
    input  cpuCtrlPkg::aluOpT                      op,
    output logic              [rvIsaPkg::xlen-1:0] y,
    output logic                                   zero
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);  // slt is signed

    always_comb begin
        unique case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluSlt:  y = {{(xlen-1){1'b0}}, lessThan};
            default: y = '0;
        endcase
    end

    // Used by beq after a subtract
    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  logic               [6:0] opcode,
    input  logic               [2:0] funct3,
    input  logic                     funct7b5,
    output cpuCtrlPkg::ctrlT         ctrl,
    output cpuCtrlPkg::aluOpT        aluOp
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    // Main decode
    always_comb begin
        ctrl = '0;  // Unknown opcode does nothing
        unique case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluMode  = modeFunct;
            end
            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluMode  = modeAdd;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluMode  = modeAdd;
            end
            opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.immStore = 1'b1;
                ctrl.aluMode  = modeAdd;
            end
            opBranch: begin
                ctrl.branch  = 1'b1;
                ctrl.aluMode = modeSub;  // Zero flag means equal
            end
            default: ctrl = '0;
        endcase
    end

    // ALU control
    always_comb begin
        aluOp = aluAdd;
        unique case (ctrl.aluMode)
            modeAdd: aluOp = aluAdd;
            modeSub: aluOp = aluSub;
            modeFunct: begin
                unique case (funct3)
                    f3Add:   aluOp = funct7b5 ? aluSub : aluAdd;
                    f3Slt:   aluOp = aluSlt;
                    f3Or:    aluOp = aluOr;
                    f3And:   aluOp = aluAnd;
                    default: aluOp = aluAdd;  // Not in the subset
                endcase
            end
            default: aluOp = aluAdd;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cpuIfs.sv ====
`default_nettype none

// Register file access from the core
interface regFileIf;
    import rvIsaPkg::*;

    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     wd;
    logic                we;
    logic [xlen-1:0]     rd1;
    logic [xlen-1:0]     rd2;

    modport core (
        output rs1, rs2, rd, wd, we,
        input  rd1, rd2
    );

    modport rf (
        input  rs1, rs2, rd, wd, we,
        output rd1, rd2
    );
endinterface

// Data memory access, one word per access
interface dataMemIf;
    import rvIsaPkg::*;

    logic [xlen-1:0] addr;
    logic [xlen-1:0] wd;
    logic            we;
    logic [xlen-1:0] rdata;

    modport core (
        output addr, wd, we,
        input  rdata
    );

    modport mem (
        input  addr, wd, we,
        output rdata
    );
endinterface

`default_nettype wire

// ==== verilog/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

    // ALU control codes, classic 4-bit encoding
    typedef enum logic [3:0] {
        aluAnd = 4'b0000,
        aluOr  = 4'b0001,
        aluAdd = 4'b0010,
        aluSub = 4'b0110,
        aluSlt = 4'b0111
    } aluOpT;

    // How the ALU operation is chosen
    typedef enum logic [1:0] {
        modeAdd   = 2'b00,  // address and addi
        modeSub   = 2'b01,  // beq compare
        modeFunct = 2'b10   // R-type, from funct3/funct7
    } aluModeT;

    // Main decode output
    typedef struct packed {
        logic    regWrite;
        logic    aluSrc;    // Second operand is the immediate
        logic    memWrite;
        logic    memToReg;  // Writeback from data memory
        logic    branch;
        aluModeT aluMode;
        logic    immStore;  // S-format immediate instead of I-format
    } ctrlT;

endpackage

`default_nettype wire

// ==== verilog/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // Datapath and register-index widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] opReg    = 7'b0110011;  // add sub and or slt
    localparam logic [6:0] opImm    = 7'b0010011;  // addi
    localparam logic [6:0] opLoad   = 7'b0000011;  // lw
    localparam logic [6:0] opStore  = 7'b0100011;  // sw
    localparam logic [6:0] opBranch = 7'b1100011;  // beq

    // funct3 codes for the R-type ALU group, inst[14:12]
    // add and sub share one code, inst[30] tells them apart
    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Or  = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

endpackage

`default_nettype wire
